//--- cu_control.f
verilog/cu_pkg.sv
verilog/cu_vertex_job_filter.sv
verilog/cu_vertex_job_dispatch.sv
verilog/cu_graph_algorithm.sv
verilog/cu_edge_write_arbiter.sv
verilog/cu_job_status.sv
verilog/cu_control.sv
verif/cu_control_assertions.sv
verif/cu_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cu_control testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module cu_control_tb -f cu_control.f \
	-o cu_control_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/cu_control_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && { echo "result: fail"; exit 1; }
grep -q "sim passed" sim.log || { echo "result: no pass line in sim.log"; exit 1; }
echo "result: pass"

//--- verif/cu_control_tb.sv
`timescale 1ns/1ps

module cu_control_tb;

	logic                clock;
	logic                rstn;
	logic                enabled_in;
	cu_pkg::wed_t        wed_in;
	logic                wed_valid;
	cu_pkg::vertex_t     vertex_in;
	logic                vertex_request;
	logic                write_alfull;
	cu_pkg::edge_write_t write_out;
	logic                cu_done;
	cu_pkg::cu_return_t  cu_return;
	cu_pkg::edge_write_t expected_q[$];
	int                  error_count;

	cu_control #(.NUM_GRAPH_CU(4)) cu_control_i (.*);

	always #5 clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// checking and reporting
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			error_count++;
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic end_run();
		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic timed_out(input string what);
		error_count++;
		$display("timeout while waiting for %s", what);
		end_run();
	endtask

	// a record must be the oldest expected edge of its vertex
	task automatic take_record(input cu_pkg::edge_write_t rec);
		int idx;
		int i;
		idx = -1;
		for (i = 0; i < expected_q.size() && idx < 0; i++) begin
			if (expected_q[i].vertex_id == rec.vertex_id) begin
				idx = i;
			end
		end
		check_value(64'(idx >= 0), 64'(1), "record from a vertex with no edges left");
		if (idx >= 0) begin
			check_value(64'(rec.edge_index), 64'(expected_q[idx].edge_index),
				"edge index of vertex record");
			expected_q.delete(idx);
		end
	endtask

	always @(posedge clock) begin
		if (rstn && write_out.valid) begin
			take_record(write_out);
		end
	end

	task automatic check_result(input int unsigned vertices, input int unsigned edges);
		check_value(64'(cu_return.vertex_count), 64'(vertices), "cu_return vertex count");
		check_value(64'(cu_return.edge_count), 64'(edges), "cu_return edge count");
		check_value(64'(expected_q.size()), 64'(0), "records never written");
	endtask

	//////////////////////////////////////////////////////////////////////
	// drivers and waits
	//////////////////////////////////////////////////////////////////////

	task automatic load_wed(input int unsigned vertices, input int unsigned edges);
		@(posedge clock);
		wed_in.num_vertices <= vertices;
		wed_in.num_edges    <= edges;
		wed_valid           <= 1'b1;
		@(posedge clock);
		wed_valid <= 1'b0;
	endtask

	task automatic wait_request();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (vertex_request !== 1'b1) begin
			cycles++;
			if (cycles > 500) begin
				timed_out("vertex_request");
			end
			@(posedge clock);
		end
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (cu_done !== 1'b1) begin
			cycles++;
			if (cycles > 3000) begin
				timed_out("cu_done");
			end
			@(posedge clock);
		end
	endtask

	// strobe one vertex after a request and note the records it owes
	task automatic send_vertex(input int unsigned id, input int unsigned degree,
		input int unsigned start);
		cu_pkg::vertex_t     v;
		cu_pkg::edge_write_t rec;
		int unsigned         e;
		v.valid      = 1'b1;
		v.id         = id;
		v.out_degree = degree;
		v.edge_start = start;
		wait_request();
		vertex_in <= v;
		for (e = 0; e < degree; e++) begin
			rec.valid      = 1'b1;
			rec.vertex_id  = id;
			rec.edge_index = start + e;
			expected_q.push_back(rec);
		end
		@(posedge clock);
		vertex_in.valid <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		check_value(64'(vertex_request), 64'(0), "vertex_request after reset");
		check_value(64'(write_out.valid), 64'(0), "write_out.valid after reset");
		check_value(64'(cu_done), 64'(0), "cu_done after reset");
		@(posedge clock);
		enabled_in <= 1'b1;
		wait_request();
	endtask

	task automatic test_single_vertex();
		load_wed(1, 3);
		send_vertex(7, 3, 100);
		wait_done();
		check_result(1, 3);
	endtask

	task automatic test_zero_degree();
		int unsigned i;
		load_wed(5, 0);
		for (i = 0; i < 5; i++) begin
			send_vertex(200 + i, 0, 0);
		end
		wait_done();
		check_result(5, 0);
	endtask

	task automatic test_random_vertices();
		int unsigned degree [40];
		int unsigned total;
		int unsigned i;
		total = 0;
		for (i = 0; i < 40; i++) begin
			degree[i] = $urandom_range(6, 0);
			total += degree[i];
		end
		load_wed(40, total);
		for (i = 0; i < 40; i++) begin
			send_vertex(300 + i, degree[i], $urandom_range(4095, 0));
		end
		wait_done();
		check_result(40, total);
	endtask

	// four vertices fill the units while the write buffer is almost full
	task automatic test_backpressure();
		load_wed(4, 10);
		write_alfull <= 1'b1;
		send_vertex(400, 2, 0);
		send_vertex(401, 3, 10);
		send_vertex(402, 2, 20);
		send_vertex(403, 3, 30);
		repeat (30) begin
			@(posedge clock);
			check_value(64'(write_out.valid), 64'(0), "write_out.valid under almost-full");
		end
		write_alfull <= 1'b0;
		wait_done();
		check_result(4, 10);
	endtask

	task automatic test_withheld_vertex();
		int cycles;
		load_wed(3, 6);
		send_vertex(500, 3, 0);
		send_vertex(501, 1, 40);
		cycles = 0;
		while (expected_q.size() != 0) begin
			cycles++;
			if (cycles > 500) begin
				timed_out("records of the first two vertices");
			end
			@(posedge clock);
		end
		// counts stay one vertex short
		repeat (20) begin
			@(posedge clock);
			check_value(64'(cu_done), 64'(0), "cu_done with one vertex withheld");
		end
		send_vertex(502, 2, 80);
		wait_done();
		check_result(3, 6);
	endtask

	initial begin
		void'($urandom(32'hc4d1_6499));
		error_count  = 0;
		clock        = 1'b0;
		rstn         = 1'b0;
		enabled_in   = 1'b0;
		wed_in       = '0;
		wed_valid    = 1'b0;
		vertex_in    = '0;
		write_alfull = 1'b0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		test_reset_state();
		test_single_vertex();
		test_zero_degree();
		test_random_vertices();
		test_backpressure();
		test_withheld_vertex();
		end_run();
	end

endmodule

//--- verif/cu_control_assertions.sv
`timescale 1ns/1ps

module cu_control_assertions #(
	parameter int NUM_GRAPH_CU = 4
) (
	input logic                    clock,
	input logic                    rstn,
	input logic                    write_alfull,
	input logic [NUM_GRAPH_CU-1:0] write_grant,
	input cu_pkg::edge_write_t     write_record [0:NUM_GRAPH_CU-1],
	input cu_pkg::edge_write_t     write_out
);

	// one winner per cycle at most
	grant_onehot: assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(write_grant))
		else $error("more than one write grant in a cycle");

	grant_alfull: assert property (@(posedge clock) disable iff (!rstn)
		write_alfull |=> (write_grant == '0))
		else $error("write grant issued while write_alfull was high");

	// the granted record leaves one cycle later
	generate
		for (genvar i = 0; i < NUM_GRAPH_CU; i++) begin : unit_output
			grant_output: assert property (@(posedge clock) disable iff (!rstn)
				write_grant[i] |=> write_out.valid
					&& (write_out.vertex_id == $past(write_record[i].vertex_id))
					&& (write_out.edge_index == $past(write_record[i].edge_index)))
				else $error("write grant of unit %0d not followed by its record", i);
		end
	endgenerate

	reset_quiet: assert property (@(posedge clock) !rstn |-> !write_out.valid)
		else $error("write_out.valid high during reset");

endmodule

bind cu_edge_write_arbiter cu_control_assertions #(
	.NUM_GRAPH_CU(NUM_GRAPH_CU)
) arbiter_assertions_i (
	.clock       (clock),
	.rstn        (rstn),
	.write_alfull(write_alfull),
	.write_grant (write_grant),
	.write_record(write_record),
	.write_out   (write_out)
);

//--- verilog/cu_control.sv
`timescale 1ns/1ps

module cu_control #(
	parameter int NUM_GRAPH_CU = 4
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                enabled_in,
	input  cu_pkg::wed_t        wed_in,
	input  logic                wed_valid,
	input  cu_pkg::vertex_t     vertex_in,
	output logic                vertex_request,
	input  logic                write_alfull,
	output cu_pkg::edge_write_t write_out,
	output logic                cu_done,
	output cu_pkg::cu_return_t  cu_return
);

	cu_pkg::vertex_t     vertex_filtered;
	logic                vertex_filtered_pulse;
	cu_pkg::vertex_t     vertex_job [0:NUM_GRAPH_CU-1];
	logic [NUM_GRAPH_CU-1:0] busy;
	logic [NUM_GRAPH_CU-1:0] write_request;
	logic [NUM_GRAPH_CU-1:0] write_grant;
	logic [NUM_GRAPH_CU-1:0] vertex_done;
	cu_pkg::edge_write_t write_record [0:NUM_GRAPH_CU-1];

	//////////////////////////////////////////////////////////////////////
	// vertex path: filter then dispatch
	//////////////////////////////////////////////////////////////////////

	cu_vertex_job_filter filter_i (
		.clock                (clock),
		.rstn                 (rstn),
		.vertex_in            (vertex_in),
		.vertex_filtered      (vertex_filtered),
		.vertex_filtered_pulse(vertex_filtered_pulse)
	);

	cu_vertex_job_dispatch #(
		.NUM_GRAPH_CU(NUM_GRAPH_CU)
	) dispatch_i (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.vertex_filtered(vertex_filtered),
		.busy           (busy),
		.vertex_job     (vertex_job),
		.vertex_request (vertex_request)
	);

	//////////////////////////////////////////////////////////////////////
	// compute units
	//////////////////////////////////////////////////////////////////////

	generate
		for (genvar i = 0; i < NUM_GRAPH_CU; i++) begin : graph_algorithm_cu
			cu_graph_algorithm cu_i (
				.clock        (clock),
				.rstn         (rstn),
				.vertex_job   (vertex_job[i]),
				.busy         (busy[i]),
				.write_request(write_request[i]),
				.write_record (write_record[i]),
				.write_grant  (write_grant[i]),
				.vertex_done  (vertex_done[i])
			);
		end
	endgenerate

	// merge the unit records onto the single write stream
	cu_edge_write_arbiter #(
		.NUM_GRAPH_CU(NUM_GRAPH_CU)
	) arbiter_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.write_alfull (write_alfull),
		.write_request(write_request),
		.write_record (write_record),
		.write_grant  (write_grant),
		.write_out    (write_out)
	);

	cu_job_status #(
		.NUM_GRAPH_CU(NUM_GRAPH_CU)
	) status_i (
		.clock                (clock),
		.rstn                 (rstn),
		.enabled_in           (enabled_in),
		.wed_in               (wed_in),
		.wed_valid            (wed_valid),
		.vertex_done          (vertex_done),
		.vertex_filtered_pulse(vertex_filtered_pulse),
		.write_valid          (write_out.valid),
		.cu_done              (cu_done),
		.cu_return            (cu_return)
	);

endmodule

//--- verilog/cu_job_status.sv
`timescale 1ns/1ps

module cu_job_status #(
	parameter int NUM_GRAPH_CU = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  cu_pkg::wed_t            wed_in,
	input  logic                    wed_valid,
	input  logic [NUM_GRAPH_CU-1:0] vertex_done,
	input  logic                    vertex_filtered_pulse,
	input  logic                    write_valid,
	output logic                    cu_done,
	output cu_pkg::cu_return_t      cu_return
);

	cu_pkg::wed_t       wed_q;
	logic               wed_seen;
	logic               wed_load;
	cu_pkg::vertex_id_t vertex_count;
	cu_pkg::vertex_id_t vertex_add;
	cu_pkg::edge_idx_t  edge_count;

	assign wed_load = enabled_in && wed_valid;

	// units finishing this cycle plus a dropped vertex
	always_comb begin
		vertex_add = cu_pkg::vertex_id_t'(vertex_filtered_pulse);
		for (int i = 0; i < NUM_GRAPH_CU; i++) begin
			vertex_add = vertex_add + cu_pkg::vertex_id_t'(vertex_done[i]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// descriptor and counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_q        <= '0;
			wed_seen     <= 1'b0;
			vertex_count <= '0;
			edge_count   <= '0;
		end else if (wed_load) begin
			// a new descriptor starts a new run
			wed_q        <= wed_in;
			wed_seen     <= 1'b1;
			vertex_count <= '0;
			edge_count   <= '0;
		end else begin
			vertex_count <= vertex_count + vertex_add;
			edge_count   <= edge_count + cu_pkg::edge_idx_t'(write_valid);
		end
	end

	// result registered one cycle behind the counters
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
		end else if (wed_load) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
		end else begin
			cu_done <= wed_seen && (vertex_count == wed_q.num_vertices)
				&& (edge_count == wed_q.num_edges);
			cu_return.vertex_count <= vertex_count;
			cu_return.edge_count   <= edge_count;
		end
	end

endmodule

//--- verilog/cu_edge_write_arbiter.sv
`timescale 1ns/1ps

module cu_edge_write_arbiter #(
	parameter int NUM_GRAPH_CU = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  logic                    write_alfull,
	input  logic [NUM_GRAPH_CU-1:0] write_request,
	input  cu_pkg::edge_write_t     write_record [0:NUM_GRAPH_CU-1],
	output logic [NUM_GRAPH_CU-1:0] write_grant,
	output cu_pkg::edge_write_t     write_out
);

	logic [NUM_GRAPH_CU-1:0] req_open;
	logic [NUM_GRAPH_CU-1:0] above_last;
	logic [NUM_GRAPH_CU-1:0] req_high;
	logic [NUM_GRAPH_CU-1:0] winner;
	logic [NUM_GRAPH_CU-1:0] last_winner;
	cu_pkg::edge_write_t     record_sel;

	// a unit granted this cycle still shows its old record, skip it once
	assign req_open = write_request & ~write_grant;

	// every position above the last winner, empty when it was the top unit
	assign above_last = -(last_winner << 1);
	assign req_high   = req_open & above_last;

	// round robin: first requester above the last winner, else wrap around
	always_comb begin
		if (|req_high) begin
			winner = req_high & (-req_high);
		end else begin
			winner = req_open & (-req_open);
		end
	end

	// record of the unit currently holding the grant
	always_comb begin
		record_sel = '0;
		for (int i = 0; i < NUM_GRAPH_CU; i++) begin
			if (write_grant[i]) begin
				record_sel = write_record[i];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// grant register and write output
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_grant                   <= '0;
			last_winner                   <= '0;
			last_winner[NUM_GRAPH_CU-1]   <= 1'b1;
			write_out                     <= '0;
		end else begin
			if (enabled_in && !write_alfull) begin
				write_grant <= winner;
				if (|winner) begin
					last_winner <= winner;
				end
			end else begin
				write_grant <= '0;
			end
			write_out.valid      <= |write_grant;
			write_out.vertex_id  <= record_sel.vertex_id;
			write_out.edge_index <= record_sel.edge_index;
		end
	end

endmodule

//--- verilog/cu_graph_algorithm.sv
`timescale 1ns/1ps

module cu_graph_algorithm (
	input  logic                clock,
	input  logic                rstn,
	input  cu_pkg::vertex_t     vertex_job,
	output logic                busy,
	output logic                write_request,
	output cu_pkg::edge_write_t write_record,
	input  logic                write_grant,
	output logic                vertex_done
);

	typedef enum logic {
		STATE_IDLE,
		STATE_WALK
	} state_t;

	state_t            state;
	cu_pkg::edge_idx_t edge_last;
	logic              last_granted;

	assign busy          = (state == STATE_WALK);
	assign write_request = (state == STATE_WALK);

	// grant for the final edge of the vertex
	assign last_granted = write_grant && (write_record.edge_index == edge_last);

	//////////////////////////////////////////////////////////////////////
	// edge walk
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state        <= STATE_IDLE;
			write_record <= '0;
			edge_last    <= '0;
			vertex_done  <= 1'b0;
		end else begin
			vertex_done <= 1'b0;
			case (state)
				STATE_IDLE: begin
					if (vertex_job.valid) begin
						// degree is never zero here, the filter removed those
						write_record.valid      <= 1'b1;
						write_record.vertex_id  <= vertex_job.id;
						write_record.edge_index <= vertex_job.edge_start;
						edge_last <= vertex_job.edge_start + vertex_job.out_degree
							- cu_pkg::edge_idx_t'(1);
						state <= STATE_WALK;
					end
				end
				STATE_WALK: begin
					if (last_granted) begin
						write_record.valid <= 1'b0;
						vertex_done        <= 1'b1;
						state              <= STATE_IDLE;
					end else if (write_grant) begin
						// next edge shows up the cycle after the grant
						write_record.edge_index <= write_record.edge_index
							+ cu_pkg::edge_idx_t'(1);
					end
				end
				default: begin
					state <= STATE_IDLE;
				end
			endcase
		end
	end

endmodule

//--- verilog/cu_vertex_job_dispatch.sv
`timescale 1ns/1ps

module cu_vertex_job_dispatch #(
	parameter int NUM_GRAPH_CU = 4
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled_in,
	input  cu_pkg::vertex_t         vertex_filtered,
	input  logic [NUM_GRAPH_CU-1:0] busy,
	output cu_pkg::vertex_t         vertex_job [0:NUM_GRAPH_CU-1],
	output logic                    vertex_request
);

	cu_pkg::vertex_t         pending;
	logic [NUM_GRAPH_CU-1:0] taken;
	logic [NUM_GRAPH_CU-1:0] idle;
	logic [NUM_GRAPH_CU-1:0] pick;
	logic                    dispatch;

	// a unit strobed last cycle is not idle until its busy shows up
	assign idle = ~busy & ~taken;

	// lowest set bit of idle
	assign pick     = idle & (-idle);
	assign dispatch = enabled_in && pending.valid && (|idle);

	// only ask for a new vertex when both stages are empty
	assign vertex_request = enabled_in && !pending.valid && !vertex_filtered.valid;

	//////////////////////////////////////////////////////////////////////
	// pending vertex
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= '0;
		end else if (vertex_filtered.valid) begin
			pending <= vertex_filtered;
		end else if (dispatch) begin
			pending.valid <= 1'b0;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// strobe to the selected unit
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			taken <= '0;
			for (int i = 0; i < NUM_GRAPH_CU; i++) begin
				vertex_job[i] <= '0;
			end
		end else begin
			// released once the unit reports busy
			taken <= (taken & ~busy) | (dispatch ? pick : '0);
			for (int i = 0; i < NUM_GRAPH_CU; i++) begin
				vertex_job[i]       <= pending;
				vertex_job[i].valid <= dispatch && pick[i];
			end
		end
	end

endmodule

//--- verilog/cu_vertex_job_filter.sv
`timescale 1ns/1ps

module cu_vertex_job_filter (
	input  logic            clock,
	input  logic            rstn,
	input  cu_pkg::vertex_t vertex_in,
	output cu_pkg::vertex_t vertex_filtered,
	output logic            vertex_filtered_pulse
);

	logic has_edges;

	// a vertex with no outgoing edges has nothing to walk
	assign has_edges = (vertex_in.out_degree != '0);

	//////////////////////////////////////////////////////////////////////
	// one register stage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_filtered       <= '0;
			vertex_filtered_pulse <= 1'b0;
		end else begin
			// payload always follows, valid only for vertices with edges
			vertex_filtered.id         <= vertex_in.id;
			vertex_filtered.out_degree <= vertex_in.out_degree;
			vertex_filtered.edge_start <= vertex_in.edge_start;
			vertex_filtered.valid      <= vertex_in.valid && has_edges;

			// dropped vertices still count as completed
			vertex_filtered_pulse <= vertex_in.valid && !has_edges;
		end
	end

endmodule

//--- verilog/cu_pkg.sv
package cu_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// vertex ids and vertex counts
	parameter int VERTEX_BITS = 32;
	// edge indices, out-degrees and edge counts
	parameter int EDGE_BITS   = 32;

	typedef logic [VERTEX_BITS-1:0] vertex_id_t;
	typedef logic [EDGE_BITS-1:0]   edge_idx_t;

	//////////////////////////////////////////////////////////////////////
	// job and record types
	//////////////////////////////////////////////////////////////////////

	// one vertex job as it enters the filter
	typedef struct packed {
		logic       valid;
		vertex_id_t id;
		edge_idx_t  out_degree;
		edge_idx_t  edge_start;
	} vertex_t;

	// one edge write record, one per edge walked
	typedef struct packed {
		logic       valid;
		vertex_id_t vertex_id;
		edge_idx_t  edge_index;
	} edge_write_t;

	// job descriptor for a run
	typedef struct packed {
		vertex_id_t num_vertices;
		edge_idx_t  num_edges;
	} wed_t;

	// result of a run
	typedef struct packed {
		vertex_id_t vertex_count;
		edge_idx_t  edge_count;
	} cu_return_t;

endpackage
